// ==== bench/sysmon_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module sysmon_clkgen (
  output logic clk_usb,             // 8 ns period
  output logic reset_i              // high for the first 5 edges
);

  initial begin
    clk_usb = 1'b0;
    forever #4 clk_usb = ~clk_usb;
  end

  initial begin
    reset_i = 1'b1;
    repeat (5) @(posedge clk_usb);
    reset_i <= 1'b0;                // released on an edge, sync reset
  end

endmodule

`default_nettype wire

// ==== bench/sysmon_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sysmon_config.svh"

module sysmon_tb
  import reg_bus_pkg::*;
  import sysmon_pkg::*;
();

  localparam int N_OPS = 1200;      // rough count of bus operations below

  logic        clk_usb;
  logic        reset_i;
  reg_cmd_t    bus;
  logic [7:0]  reg_datao;
  sensor_t     sensor;
  logic        error;
  logic [11:0] temp_out;

  logic [15:0] mem_model [128];     // mirror of the DRP register file
  alarm_t      sticky_model;        // mirror of STAT
  logic [31:0] seed_ret;

  sysmon_clkgen u_clkgen (.clk_usb(clk_usb), .reset_i(reset_i));

  sysmon_top UUT (
    .clk_usb   (clk_usb),
    .reset_i   (reset_i),
    .bus       (bus),
    .reg_datao (reg_datao),
    .sensor    (sensor),
    .error     (error),
    .temp_out  (temp_out)
  );

  task automatic fail(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) fail($sformatf("%s read %02h, expected %02h", what, got, exp));
  endtask

  task automatic check_alarm(input alarm_t got, input logic err, input alarm_t exp,
                             input string what);
    if (got !== exp) fail($sformatf("%s STAT %05b, expected %05b", what, got, exp));
    if (err !== |exp) fail($sformatf("%s error %b, expected %b", what, err, |exp));
  endtask

  task automatic check_temp(input logic [11:0] got, input logic [11:0] exp);
    if (got !== exp) fail($sformatf("temp_out %03h, expected %03h", got, exp));
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_usb);
  endtask

  // one write strobe, bus idle again next cycle
  task automatic bus_write(input logic [7:0] addr, input logic [6:0] bc, input logic [7:0] d);
    @(posedge clk_usb);
    bus <= '{address: addr, bytecnt: bc, datai: d, read: 1'b0, write: 1'b1};
    @(posedge clk_usb);
    bus <= '0;
  endtask

  // read data is comb, sampled mid cycle
  task automatic bus_read(input logic [7:0] addr, input logic [6:0] bc, output logic [7:0] d);
    @(posedge clk_usb);
    bus <= '{address: addr, bytecnt: bc, datai: 8'h00, read: 1'b1, write: 1'b0};
    @(negedge clk_usb);
    d = reg_datao;
  endtask

  function automatic logic is_meas(input logic [6:0] a);
    return a == `SYSMON_DRP_TEMP || a == `SYSMON_DRP_VCCINT ||
           a == `SYSMON_DRP_VCCAUX || a == `SYSMON_DRP_VBRAM;
  endfunction

  // expected DRP word, measurements come from the held sensor
  function automatic logic [15:0] drp_expect(input logic [6:0] a);
    case (a)
      `SYSMON_DRP_TEMP:   return {sensor.temp, 4'h0};
      `SYSMON_DRP_VCCINT: return {sensor.vccint, 4'h0};
      `SYSMON_DRP_VCCAUX: return {sensor.vccaux, 4'h0};
      `SYSMON_DRP_VBRAM:  return {sensor.vbram, 4'h0};
      default:            return mem_model[a];
    endcase
  endfunction

  // value above bits 15:4 of its limit
  function automatic alarm_t alarm_rule(input sensor_t s);
    alarm_t a;
    a.ot        = s.temp > mem_model[`SYSMON_DRP_LIM_OT][15:4];
    a.user_temp = s.temp > mem_model[`SYSMON_DRP_LIM_TEMP][15:4];
    a.vccint    = s.vccint > mem_model[`SYSMON_DRP_LIM_VCCINT][15:4];
    a.vccaux    = s.vccaux > mem_model[`SYSMON_DRP_LIM_VCCAUX][15:4];
    a.vbram     = s.vbram > mem_model[`SYSMON_DRP_LIM_VBRAM][15:4];
    return a;
  endfunction

  task automatic drp_write(input logic [6:0] a, input logic [15:0] w);
    bus_write(`SYSMON_REG_DRP_DATA, 7'd0, w[7:0]);
    bus_write(`SYSMON_REG_DRP_DATA, 7'd1, w[15:8]);
    bus_write(`SYSMON_REG_DRP_ADDR, 7'd0, {1'b1, a});
    wait_cycles(2);                 // keeps launches apart
    if (!is_meas(a)) mem_model[a] = w;
  endtask

  task automatic drp_read_check(input logic [6:0] a, input string what);
    logic [7:0]  b;
    logic [15:0] exp;
    exp = drp_expect(a);
    bus_write(`SYSMON_REG_DRP_ADDR, 7'd0, {1'b0, a});
    wait_cycles(2);                 // den, drdy, capture
    bus_read(`SYSMON_REG_DRP_ADDR, 7'd0, b);
    check_byte(b, {1'b0, a}, {what, " addr reg"});
    bus_read(`SYSMON_REG_DRP_DATA, 7'd0, b);
    check_byte(b, exp[7:0], $sformatf("%s addr %02h low", what, a));
    bus_read(`SYSMON_REG_DRP_DATA, 7'd1, b);
    check_byte(b, exp[15:8], $sformatf("%s addr %02h high", what, a));
  endtask

  task automatic stat_check(input string what);
    logic [7:0] b;
    bus_read(`SYSMON_REG_STAT, 7'd0, b);
    check_alarm(alarm_t'(b[4:0]), error, sticky_model, what);
    check_byte(b & 8'he0, 8'h00, {what, " STAT top bits"});
  endtask

  logic [6:0] lim_addr [5];

  initial begin
    #(N_OPS * 20 * 8);
    $display("Timeout: the test did not finish in the expected time");
    $display("Checks failed");
    $fatal(1);
  end

  initial begin
    logic [6:0]  a;
    logic [7:0]  b;
    logic [7:0]  u;
    sensor_t     s;
    alarm_t      exp_now;
    seed_ret = $urandom(32'h71da);
    bus    <= '0;
    sensor <= '0;
    lim_addr = '{`SYSMON_DRP_LIM_TEMP, `SYSMON_DRP_LIM_VCCINT, `SYSMON_DRP_LIM_VCCAUX,
                 `SYSMON_DRP_LIM_OT, `SYSMON_DRP_LIM_VBRAM};
    for (int i = 0; i < 128; i++) mem_model[i] = 16'h0000;
    for (int i = 0; i < 5; i++) mem_model[lim_addr[i]] = 16'hffff;
    sticky_model = '0;
    @(negedge reset_i);
    wait_cycles(1);

    // reset state
    stat_check("reset");
    for (int i = 0; i < 5; i++) drp_read_check(lim_addr[i], "reset limit");

    // random DRP traffic, sensor at 0 so no limit can alarm
    for (int n = 0; n < 40; n++) begin
      if ($urandom_range(0, 3) == 0) a = lim_addr[$urandom_range(0, 4)];
      else begin
        do a = 7'($urandom_range(0, 127)); while (is_meas(a));
      end
      drp_write(a, 16'($urandom));
      wait_cycles(1);
      drp_read_check(a, "scratch");
    end

    // measurement readback, writes there are dropped
    s = sensor_t'({$urandom, $urandom});
    @(posedge clk_usb);
    sensor <= s;
    @(negedge clk_usb);
    @(negedge clk_usb);             // one edge later the sample is out
    check_temp(temp_out, s.temp);
    drp_read_check(`SYSMON_DRP_TEMP, "meas");
    drp_read_check(`SYSMON_DRP_VCCINT, "meas");
    drp_read_check(`SYSMON_DRP_VCCAUX, "meas");
    drp_read_check(`SYSMON_DRP_VBRAM, "meas");
    drp_write(`SYSMON_DRP_VCCAUX, 16'($urandom));
    drp_read_check(`SYSMON_DRP_VCCAUX, "meas after write");

    // alarms, sticky hold and clear
    for (int n = 0; n < 25; n++) begin
      @(posedge clk_usb);
      sensor <= '0;
      wait_cycles(3);
      bus_write(`SYSMON_REG_STAT, 7'd0, 8'h00);
      sticky_model = '0;
      for (int i = 0; i < 5; i++) drp_write(lim_addr[i], 16'($urandom));
      wait_cycles(3);
      stat_check("cleared");
      s = sensor_t'({$urandom, $urandom});
      exp_now = alarm_rule(s);
      @(posedge clk_usb);
      sensor <= s;
      @(negedge clk_usb);
      check_temp(temp_out, 12'h000); // old sample still out
      @(negedge clk_usb);
      check_temp(temp_out, s.temp);
      @(negedge clk_usb);
      if (error !== 1'b0) fail("error raised before the 3-cycle latency");
      @(negedge clk_usb);           // third edge after the sensor change
      sticky_model = sticky_model | exp_now;
      if (error !== |sticky_model) fail("error wrong 3 cycles after sensor change");
      stat_check("alarm");
      @(posedge clk_usb);
      sensor <= '0;                 // drop below every limit
      wait_cycles(4);
      stat_check("sticky hold");
      if ($urandom_range(0, 1)) begin
        @(posedge clk_usb);
        sensor <= s;                // condition back and persisting
        wait_cycles(4);
      end
      exp_now = alarm_rule(sensor);
      bus_write(`SYSMON_REG_STAT, 7'd0, 8'h00);
      wait_cycles(3);
      sticky_model = exp_now;
      stat_check("after clear");
    end

    // unmapped and read-low cycles
    for (int n = 0; n < 30; n++) begin
      do u = 8'($urandom); while (u inside {`SYSMON_REG_DRP_ADDR, `SYSMON_REG_DRP_DATA,
                                             `SYSMON_REG_STAT});
      bus_read(u, 7'($urandom), b);
      check_byte(b, 8'h00, "unmapped");
      @(posedge clk_usb);
      bus <= '{address: `SYSMON_REG_DRP_ADDR, bytecnt: 7'd0, datai: 8'h00,
               read: 1'b0, write: 1'b0};
      @(negedge clk_usb);
      check_byte(reg_datao, 8'h00, "read low");
    end

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== include/sysmon_config.svh ====
`ifndef SYSMON_CONFIG_SVH
`define SYSMON_CONFIG_SVH

// register bus
`define SYSMON_BYTECNT_SIZE 7            // byte count width on the bus

`define SYSMON_REG_DRP_ADDR 8'd81        // DRP address, bit 7 set = write
`define SYSMON_REG_DRP_DATA 8'd82        // DRP data, byte per bytecnt
`define SYSMON_REG_STAT     8'd83        // sticky alarms, write clears

// DRP map, measurement results are read only
`define SYSMON_DRP_TEMP     7'h00
`define SYSMON_DRP_VCCINT   7'h01
`define SYSMON_DRP_VCCAUX   7'h02
`define SYSMON_DRP_VBRAM    7'h06

// upper limits, compared on bits 15:4
`define SYSMON_DRP_LIM_TEMP   7'h50      // user temp alarm
`define SYSMON_DRP_LIM_VCCINT 7'h51
`define SYSMON_DRP_LIM_VCCAUX 7'h52
`define SYSMON_DRP_LIM_OT     7'h53      // over-temperature
`define SYSMON_DRP_LIM_VBRAM  7'h58

`endif

// ==== logic/reg_bus_pkg.sv ====
`default_nettype none

`include "sysmon_config.svh"

// register bus as seen by every register block on the board controller
package reg_bus_pkg;

  // one bus cycle from the USB side
  typedef struct packed {
    logic [7:0]                      address;  // register select
    logic [`SYSMON_BYTECNT_SIZE-1:0] bytecnt;  // byte index in multi-byte reg
    logic [7:0]                      datai;    // write data
    logic                            read;     // read strobe
    logic                            write;    // write strobe
  } reg_cmd_t;

endpackage

`default_nettype wire

// ==== logic/sysmon_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sysmon_config.svh"

module sysmon_core
  import sysmon_pkg::*;
(
  input  wire           clk_usb,
  input  wire           reset_i,
  input  wire drp_req_t drp_req,    // from register window
  output drp_rsp_t      drp_rsp,    // drdy one cycle after den
  input  wire sensor_t  sensor,     // raw readings
  output alarm_t        alarm,      // registered alarm levels
  output logic [11:0]   temp_out    // sampled temperature
);

  logic [15:0] drp_mem [128];       // DRP register file
  sensor_t     sample;              // sensor registered every cycle
  logic [15:0] rd_word;             // word at drp_req.addr
  logic        meas_hit;            // addr is a read-only measurement
  logic [15:0] dout_q;
  logic        drdy_q;

  // channel above its limit, limit kept in bits 15:4
  function automatic logic over_limit(input logic [11:0] value, input logic [15:0] limit);
    return value > limit[15:4];
  endfunction

  // measurements come from the sample, left aligned like the limits
  always_comb begin
    meas_hit = 1'b1;
    case (drp_req.addr)
      `SYSMON_DRP_TEMP:   rd_word = {sample.temp, 4'h0};
      `SYSMON_DRP_VCCINT: rd_word = {sample.vccint, 4'h0};
      `SYSMON_DRP_VCCAUX: rd_word = {sample.vccaux, 4'h0};
      `SYSMON_DRP_VBRAM:  rd_word = {sample.vbram, 4'h0};
      default: begin
        rd_word  = drp_mem[drp_req.addr];
        meas_hit = 1'b0;
      end
    endcase
  end

  // register file, limits come up at all ones so nothing alarms
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      for (int i = 0; i < 128; i++) begin
        drp_mem[i] <= 16'h0000;
      end
      drp_mem[`SYSMON_DRP_LIM_TEMP]   <= 16'hffff;
      drp_mem[`SYSMON_DRP_LIM_VCCINT] <= 16'hffff;
      drp_mem[`SYSMON_DRP_LIM_VCCAUX] <= 16'hffff;
      drp_mem[`SYSMON_DRP_LIM_OT]     <= 16'hffff;
      drp_mem[`SYSMON_DRP_LIM_VBRAM]  <= 16'hffff;
    end else if (drp_req.den && drp_req.dwe && !meas_hit) begin
      drp_mem[drp_req.addr] <= drp_req.din;    // writes to measurements dropped
    end
  end

  // sampling, DRP answer and limit compares
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      sample <= '0;
      drdy_q <= 1'b0;
      dout_q <= 16'h0000;
      alarm  <= '0;
    end else begin
      sample <= sensor;                         // every cycle
      drdy_q <= drp_req.den;                    // fixed one-cycle latency
      if (drp_req.den) begin
        dout_q <= rd_word;                      // contents before any write
      end
      // compares run on the sample, one stage behind it
      alarm.ot        <= over_limit(sample.temp, drp_mem[`SYSMON_DRP_LIM_OT]);
      alarm.user_temp <= over_limit(sample.temp, drp_mem[`SYSMON_DRP_LIM_TEMP]);
      alarm.vccint    <= over_limit(sample.vccint, drp_mem[`SYSMON_DRP_LIM_VCCINT]);
      alarm.vccaux    <= over_limit(sample.vccaux, drp_mem[`SYSMON_DRP_LIM_VCCAUX]);
      alarm.vbram     <= over_limit(sample.vbram, drp_mem[`SYSMON_DRP_LIM_VBRAM]);
    end
  end

  assign drp_rsp  = '{dout: dout_q, drdy: drdy_q};
  assign temp_out = sample.temp;                // one cycle behind sensor

endmodule

`default_nettype wire

// ==== logic/sysmon_pkg.sv ====
`default_nettype none

// DRP port and sensor side of the system monitor
package sysmon_pkg;

  // DRP request, den pulses for one cycle
  typedef struct packed {
    logic [6:0]  addr;   // register file index
    logic [15:0] din;    // write word
    logic        den;    // enable pulse
    logic        dwe;    // write when set
  } drp_req_t;

  // DRP response, dout valid with drdy
  typedef struct packed {
    logic [15:0] dout;   // register contents
    logic        drdy;   // one cycle after den
  } drp_rsp_t;

  // raw 12-bit sensor readings
  typedef struct packed {
    logic [11:0] temp;
    logic [11:0] vccint;
    logic [11:0] vccaux;
    logic [11:0] vbram;
  } sensor_t;

  // declared msb first, so ot lands in bit 0 of STAT
  typedef struct packed {
    logic vbram;         // bit 4
    logic vccaux;        // bit 3
    logic vccint;        // bit 2
    logic user_temp;     // bit 1
    logic ot;            // bit 0
  } alarm_t;

endpackage

`default_nettype wire

// ==== logic/sysmon_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "sysmon_config.svh"

module sysmon_regs
  import reg_bus_pkg::*;
  import sysmon_pkg::*;
(
  input  wire           clk_usb,
  input  wire           reset_i,
  input  wire reg_cmd_t bus,        // register bus cycle
  output logic [7:0]    reg_datao,  // read data, comb from bus
  output drp_req_t      drp_req,    // to core DRP port
  input  wire drp_rsp_t drp_rsp,    // from core DRP port
  input  wire alarm_t   alarm,      // alarm levels, registered in core
  output logic          error       // any sticky bit set
);

  // DRP writes: load data bytes, then write DRP_ADDR with bit 7 set
  // DRP reads: write DRP_ADDR with bit 7 clear, then read DRP_DATA bytes

  logic [6:0]  drp_addr;            // last address, bit 7 stripped
  logic [15:0] drp_din;             // staged write word
  logic        drp_den;             // one-cycle enable
  logic        drp_dwe;             // held with addr
  logic        pend_read;           // outstanding request is a read
  logic [15:0] rd_data;             // dout of last DRP read
  alarm_t      sticky;              // caught alarms, held until cleared

  logic        wr_addr;             // write strobe to DRP_ADDR
  logic        wr_data;             // write strobe to DRP_DATA
  logic        wr_stat;             // write strobe to STAT
  logic [3:0]  byte_sel;            // bit offset of selected byte, 0 or 8

  assign wr_addr  = bus.write && (bus.address == `SYSMON_REG_DRP_ADDR);
  assign wr_data  = bus.write && (bus.address == `SYSMON_REG_DRP_DATA);
  assign wr_stat  = bus.write && (bus.address == `SYSMON_REG_STAT);
  assign byte_sel = {bus.bytecnt[0], 3'b000};   // only two bytes in the word

  // read mux, zero when not reading or unmapped
  always_comb begin
    reg_datao = 8'h00;
    if (bus.read) begin
      case (bus.address)
        `SYSMON_REG_DRP_ADDR: reg_datao = {1'b0, drp_addr};
        `SYSMON_REG_DRP_DATA: reg_datao = rd_data[byte_sel +: 8];
        `SYSMON_REG_STAT:     reg_datao = {3'b000, sticky};
        default:              reg_datao = 8'h00;
      endcase
    end
  end

  // DRP launch, den one cycle after the address write
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      drp_addr  <= 7'h00;
      drp_den   <= 1'b0;
      drp_dwe   <= 1'b0;
      pend_read <= 1'b0;
    end else begin
      drp_den <= wr_addr;                       // single pulse per write
      if (wr_addr) begin
        drp_addr  <= bus.datai[6:0];
        drp_dwe   <= bus.datai[7];              // top bit picks write
        pend_read <= ~bus.datai[7];
      end else if (drp_rsp.drdy) begin
        pend_read <= 1'b0;                      // request answered
      end
    end
  end

  // write word staging and read capture, payload only
  always_ff @(posedge clk_usb) begin
    if (wr_data) begin
      drp_din[byte_sel +: 8] <= bus.datai;      // fill one byte
    end
    if (drp_rsp.drdy && pend_read) begin
      rd_data <= drp_rsp.dout;                  // readable the next cycle
    end
  end

  // alarms can be short, so latch each bit until STAT is written
  always_ff @(posedge clk_usb) begin
    if (reset_i) begin
      sticky <= '0;
    end else if (wr_stat) begin
      sticky <= '0;                             // clear wins over new alarms
    end else begin
      sticky <= sticky | alarm;
    end
  end

  assign drp_req = '{addr: drp_addr, din: drp_din, den: drp_den, dwe: drp_dwe};
  assign error   = |sticky;

endmodule

`default_nettype wire

// ==== logic/sysmon_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sysmon_top
  import reg_bus_pkg::*;
  import sysmon_pkg::*;
(
  input  wire           clk_usb,
  input  wire           reset_i,
  input  wire reg_cmd_t bus,        // register bus from USB side
  output logic [7:0]    reg_datao,  // register read data
  input  wire sensor_t  sensor,     // raw sensor readings
  output logic          error,      // sticky alarm summary
  output logic [11:0]   temp_out    // sampled temperature
);

  drp_req_t drp_req;                // window to core
  drp_rsp_t drp_rsp;                // core to window
  alarm_t   alarm;                  // registered alarm levels

  sysmon_regs u_regs (
    .clk_usb   (clk_usb),
    .reset_i   (reset_i),
    .bus       (bus),
    .reg_datao (reg_datao),
    .drp_req   (drp_req),
    .drp_rsp   (drp_rsp),
    .alarm     (alarm),
    .error     (error)
  );

  sysmon_core u_core (
    .clk_usb   (clk_usb),
    .reset_i   (reset_i),
    .drp_req   (drp_req),
    .drp_rsp   (drp_rsp),
    .sensor    (sensor),
    .alarm     (alarm),
    .temp_out  (temp_out)
  );

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
logic/reg_bus_pkg.sv
logic/sysmon_pkg.sv
logic/sysmon_regs.sv
logic/sysmon_core.sv
logic/sysmon_top.sv
bench/sysmon_clkgen.sv
bench/sysmon_tb.sv
